// ==== logic/gfx_pkg.sv ====
// ==================================================================
// shared geometry, raster timing and widths for the line renderer
// plus the line drawer state type
// ==================================================================

package gfx_pkg;

    // coordinate and colour widths
    localparam int CORDW = 16;          // signed coordinate width
    localparam int CIDXW = 4;           // colour index width
    localparam int CHANW = 4;           // one colour channel
    localparam int COLRW = 3*CHANW;     // rgb over three channels

    // framebuffer geometry
    localparam int FB_WIDTH  = 64;
    localparam int FB_HEIGHT = 48;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);

    // raster timing with active high sync
    localparam int H_TOTAL      = 80;   // clocks per line
    localparam int H_SYNC_START = 68;
    localparam int H_SYNC_END   = 75;   // last clock of hsync
    localparam int V_TOTAL      = 52;   // lines per frame
    localparam int V_SYNC_START = 49;
    localparam int V_SYNC_END   = 50;   // last line of vsync

    // pipeline latencies
    localparam int LAT_ADDR = 3;        // point to ram write
    localparam int LAT_SCAN = 2;        // counters to video out

    // line drawer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_INIT,
        ST_DRAW,
        ST_DONE
    } draw_state_t;

endpackage

// ==== logic/line_drawer.sv ====
// ==================================================================
// bresenham line stepper at one point per cycle
// ==================================================================

`timescale 1ns/1ps

module line_drawer import gfx_pkg::*; (
    input  logic                    clk_sys,
    input  logic                    rst_sys,
    input  logic                    start,     // one-cycle request strobe
    input  logic signed [CORDW-1:0] x0,
    input  logic signed [CORDW-1:0] y0,
    input  logic signed [CORDW-1:0] x1,
    input  logic signed [CORDW-1:0] y1,
    input  logic        [CIDXW-1:0] cidx,
    output logic signed [CORDW-1:0] px,        // current point
    output logic signed [CORDW-1:0] py,
    output logic                    pen,       // point valid
    output logic        [CIDXW-1:0] pcidx,
    output logic                    drawing,
    output logic                    done
);

    draw_state_t state;

    logic signed [CORDW-1:0] x, y;             // walking point
    logic signed [CORDW-1:0] x_end, y_end;     // target point
    logic        [CIDXW-1:0] cidx_r;

    // deltas one bit wider so full-range lines fit
    logic signed [CORDW:0]   dx;               // non-negative abs x delta
    logic signed [CORDW:0]   dy;               // negated abs y delta
    logic signed [CORDW:0]   adx, ndy;         // deltas from latched points
    logic signed [CORDW+1:0] err;              // error term
    logic signed [CORDW+1:0] err_next;
    logic signed [CORDW+2:0] e2;               // twice the error
    logic                    x_neg, y_neg;     // step directions
    logic                    movx, movy;
    logic                    last;             // at end point

    // delta setup for ST_INIT
    always_comb begin
        adx = (x_end > x) ? x_end - x : x - x_end;
        ndy = (y_end > y) ? y - y_end : y_end - y;
    end

    // step decision
    always_comb begin
        e2       = err + err;
        movx     = (e2 >= dy);
        movy     = (e2 <= dx);
        last     = (x == x_end) && (y == y_end);
        err_next = err;
        if (movx) err_next = err_next + dy;
        if (movy) err_next = err_next + dx;
    end

    // control fsm
    always_ff @(posedge clk_sys) begin
        case (state)
            ST_IDLE, ST_DONE: begin  // a new request may follow done directly
                if (start) begin
                    state <= ST_INIT;
                end else begin
                    state <= ST_IDLE;
                end
            end
            ST_INIT: state <= ST_DRAW;
            ST_DRAW: if (last) state <= ST_DONE;  // end point is out this cycle
            default: state <= ST_IDLE;
        endcase
        if (rst_sys) state <= ST_IDLE;
    end

    // point and delta registers
    always_ff @(posedge clk_sys) begin
        case (state)
            ST_IDLE, ST_DONE: begin
                if (start) begin  // latch request
                    x      <= x0;
                    y      <= y0;
                    x_end  <= x1;
                    y_end  <= y1;
                    cidx_r <= cidx;
                end
            end
            ST_INIT: begin
                dx    <= adx;
                dy    <= ndy;
                err   <= adx + ndy;  // dx plus negative dy
                x_neg <= (x_end < x);
                y_neg <= (y_end < y);
            end
            ST_DRAW: begin
                if (!last) begin
                    if (movx) x <= x_neg ? x - 1'b1 : x + 1'b1;
                    if (movy) y <= y_neg ? y - 1'b1 : y + 1'b1;
                    err <= err_next;
                end
            end
            default: ;
        endcase
    end

    // outputs straight from state and point registers
    assign px      = x;
    assign py      = y;
    assign pcidx   = cidx_r;
    assign drawing = (state == ST_DRAW);
    assign pen     = (state == ST_DRAW);   // every draw cycle is a point
    assign done    = (state == ST_DONE);   // one cycle with drawing already low

endmodule

// ==== logic/fb_write_addr.sv ====
// ==================================================================
// three-stage clip and framebuffer address pipeline
// ==================================================================

`timescale 1ns/1ps

module fb_write_addr import gfx_pkg::*; (
    input  logic                    clk_sys,
    input  logic                    rst_sys,
    input  logic signed [CORDW-1:0] px,
    input  logic signed [CORDW-1:0] py,
    input  logic                    pen,
    input  logic        [CIDXW-1:0] pcidx,
    output logic                    we_fb,
    output logic     [FB_ADDRW-1:0] addr_fb,
    output logic        [CIDXW-1:0] cidx_fb
);

    logic                in_bounds;       // point lands inside the buffer
    logic [LAT_ADDR-1:0] en_sr;           // write enable chain
    logic [FB_ADDRW-1:0] row_s1, x_s1;    // stage 1 address parts
    logic [FB_ADDRW-1:0] addr_s2;
    logic [CIDXW-1:0]    cidx_s1, cidx_s2;

    // negative or past the edge is dropped and never wrapped
    assign in_bounds = (px >= 0) && (px < FB_WIDTH) && (py >= 0) && (py < FB_HEIGHT);

    // enable travels beside the address
    always_ff @(posedge clk_sys) begin
        en_sr <= {en_sr[LAT_ADDR-2:0], pen && in_bounds};
        if (rst_sys) en_sr <= '0;
    end

    always_ff @(posedge clk_sys) begin
        // stage 1 row product
        row_s1  <= FB_ADDRW'(py * FB_WIDTH);
        x_s1    <= FB_ADDRW'(px);
        cidx_s1 <= pcidx;
        // stage 2 adds the column
        addr_s2 <= row_s1 + x_s1;
        cidx_s2 <= cidx_s1;
        // stage 3 write port registers
        addr_fb <= addr_s2;
        cidx_fb <= cidx_s2;
    end

    assign we_fb = en_sr[LAT_ADDR-1];

endmodule

// ==== logic/framebuffer_ram.sv ====
// ==================================================================
// simple dual-port framebuffer ram of colour indices
// ==================================================================

`timescale 1ns/1ps

module framebuffer_ram import gfx_pkg::*; (
    input  logic                clk_sys,
    input  logic                we,
    input  logic [FB_ADDRW-1:0] wr_addr,
    input  logic [CIDXW-1:0]    wr_cidx,
    input  logic [FB_ADDRW-1:0] rd_addr,
    output logic [CIDXW-1:0]    rd_cidx    // one cycle after rd_addr
);

    logic [CIDXW-1:0] mem [FB_PIXELS];

    initial begin
        for (int i = 0; i < FB_PIXELS; i++) mem[i] = '0;  // blank image
    end

    // same-address read sees the old word
    always_ff @(posedge clk_sys) begin
        if (we) mem[wr_addr] <= wr_cidx;
        rd_cidx <= mem[rd_addr];
    end

endmodule

// ==== logic/raster_scanout.sv ====
// ==================================================================
// raster counters, framebuffer readout, palette lookup
// and aligned sync, enable and rgb outputs
// ==================================================================

`timescale 1ns/1ps

module raster_scanout import gfx_pkg::*; (
    input  logic                clk_sys,
    input  logic                rst_sys,
    input  logic [CIDXW-1:0]    rd_cidx,   // index for last cycle's rd_addr
    output logic [FB_ADDRW-1:0] rd_addr,
    output logic                hsync,
    output logic                vsync,
    output logic                de,
    output logic                frame,
    output logic [CHANW-1:0]    vga_r,
    output logic [CHANW-1:0]    vga_g,
    output logic [CHANW-1:0]    vga_b
);

    logic [$clog2(H_TOTAL)-1:0] h;         // clock within line
    logic [$clog2(V_TOTAL)-1:0] v;         // line within frame
    logic line_end, frame_end;
    logic active;                          // current position is a pixel

    // stage 1 lined up with the ram read
    logic hs_s1, vs_s1, de_s1, frame_s1;

    logic [COLRW-1:0] pal_colr;

    always_comb begin
        line_end  = (h == H_TOTAL-1);
        frame_end = line_end && (v == V_TOTAL-1);
        active    = (h < FB_WIDTH) && (v < FB_HEIGHT);
    end

    // free-running counters
    always_ff @(posedge clk_sys) begin
        if (line_end) begin
            h <= '0;
            v <= (v == V_TOTAL-1) ? '0 : v + 1'b1;
        end else begin
            h <= h + 1'b1;
        end
        if (rst_sys) begin
            h <= '0;
            v <= '0;
        end
    end

    // read address walks active pixels only
    always_ff @(posedge clk_sys) begin
        if (frame_end) begin
            rd_addr <= '0;
        end else if (active) begin
            rd_addr <= rd_addr + 1'b1;
        end
        if (rst_sys) rd_addr <= '0;
    end

    // stage 1 timing flags wait one cycle for the ram
    always_ff @(posedge clk_sys) begin
        hs_s1    <= (h >= H_SYNC_START) && (h <= H_SYNC_END);
        vs_s1    <= (v >= V_SYNC_START) && (v <= V_SYNC_END);
        de_s1    <= active;
        frame_s1 <= (h == 0) && (v == 0);
        if (rst_sys) begin
            hs_s1    <= 1'b0;
            vs_s1    <= 1'b0;
            de_s1    <= 1'b0;
            frame_s1 <= 1'b0;
        end
    end

    // fixed palette with 0 black and 15 white
    always_comb begin
        case (rd_cidx)
            4'h0:    pal_colr = 12'h000;
            4'h1:    pal_colr = 12'hF00;  // red
            4'h2:    pal_colr = 12'h0F0;  // green
            4'h3:    pal_colr = 12'h00F;  // blue
            4'h4:    pal_colr = 12'hFF0;
            4'h5:    pal_colr = 12'h0FF;
            4'h6:    pal_colr = 12'hF0F;
            4'h7:    pal_colr = 12'h888;  // mid grey
            4'h8:    pal_colr = 12'h800;
            4'h9:    pal_colr = 12'h080;
            4'hA:    pal_colr = 12'h008;
            4'hB:    pal_colr = 12'h880;
            4'hC:    pal_colr = 12'h088;
            4'hD:    pal_colr = 12'h808;
            4'hE:    pal_colr = 12'hF80;  // orange
            default: pal_colr = 12'hFFF;
        endcase
    end

    // stage 2 video outputs
    always_ff @(posedge clk_sys) begin
        hsync <= hs_s1;
        vsync <= vs_s1;
        de    <= de_s1;
        frame <= frame_s1;
        if (de_s1) begin
            {vga_r, vga_g, vga_b} <= pal_colr;
        end else begin  // black in blanking
            {vga_r, vga_g, vga_b} <= '0;
        end
        if (rst_sys) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            frame <= 1'b0;
            {vga_r, vga_g, vga_b} <= '0;
        end
    end

endmodule

// ==== logic/line_render_top.sv ====
// ==================================================================
// line renderer top with drawer, address pipeline, framebuffer
// and scanout
// ==================================================================

`timescale 1ns/1ps

module line_render_top import gfx_pkg::*; (
    input  logic                    clk_sys,
    input  logic                    rst_sys,
    input  logic                    start,
    input  logic signed [CORDW-1:0] x0,
    input  logic signed [CORDW-1:0] y0,
    input  logic signed [CORDW-1:0] x1,
    input  logic signed [CORDW-1:0] y1,
    input  logic        [CIDXW-1:0] cidx,
    output logic                    drawing,
    output logic                    done,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    de,
    output logic                    frame,
    output logic        [CHANW-1:0] vga_r,
    output logic        [CHANW-1:0] vga_g,
    output logic        [CHANW-1:0] vga_b
);

    // draw path
    logic signed [CORDW-1:0] px, py;
    logic                    pen;
    logic        [CIDXW-1:0] pcidx;
    logic                    we_fb;
    logic     [FB_ADDRW-1:0] addr_fb;
    logic        [CIDXW-1:0] cidx_fb;

    // scan path
    logic     [FB_ADDRW-1:0] rd_addr;
    logic        [CIDXW-1:0] rd_cidx;

    line_drawer line_drawer_inst (
        .clk_sys, .rst_sys, .start,
        .x0, .y0, .x1, .y1, .cidx,
        .px, .py, .pen, .pcidx,
        .drawing, .done
    );

    fb_write_addr fb_write_addr_inst (
        .clk_sys, .rst_sys,
        .px, .py, .pen, .pcidx,
        .we_fb, .addr_fb, .cidx_fb
    );

    framebuffer_ram framebuffer_ram_inst (
        .clk_sys,
        .we(we_fb),
        .wr_addr(addr_fb),
        .wr_cidx(cidx_fb),
        .rd_addr,
        .rd_cidx
    );

    raster_scanout raster_scanout_inst (
        .clk_sys, .rst_sys,
        .rd_cidx, .rd_addr,
        .hsync, .vsync, .de, .frame,
        .vga_r, .vga_g, .vga_b
    );

endmodule

// ==== bench/line_render_tb.sv ====
// ==================================================================
// testbench for the line renderer with a bresenham model, shadow
// image, record reader and full frame comparison against the palette
// ==================================================================

`timescale 1ns/1ps

module line_render_tb import gfx_pkg::*; ();

    logic                    clk_sys;
    logic                    rst_sys;
    logic                    start;
    logic signed [CORDW-1:0] x0, y0, x1, y1;
    logic        [CIDXW-1:0] cidx;
    logic                    drawing, done;
    logic                    hsync, vsync, de, frame;
    logic        [CHANW-1:0] vga_r, vga_g, vga_b;

    logic [CIDXW-1:0] shadow [FB_PIXELS];   // expected framebuffer contents
    int               frames_checked;
    int               lines_drawn;

    line_render_top UUT (
        .clk_sys, .rst_sys, .start,
        .x0, .y0, .x1, .y1, .cidx,
        .drawing, .done,
        .hsync, .vsync, .de, .frame,
        .vga_r, .vga_g, .vga_b
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;      // 8 ns period
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string what);
        $display("error at %0t ns: %s", $time, what);
        abort_run();
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        abort_run();
    endtask

    // expected palette with 0 black and 15 white
    function automatic logic [COLRW-1:0] palette_colr(input logic [CIDXW-1:0] idx);
        case (idx)
            4'h0:    return 12'h000;
            4'h1:    return 12'hF00;
            4'h2:    return 12'h0F0;
            4'h3:    return 12'h00F;
            4'h4:    return 12'hFF0;
            4'h5:    return 12'h0FF;
            4'h6:    return 12'hF0F;
            4'h7:    return 12'h888;
            4'h8:    return 12'h800;
            4'h9:    return 12'h080;
            4'hA:    return 12'h008;
            4'hB:    return 12'h880;
            4'hC:    return 12'h088;
            4'hD:    return 12'h808;
            4'hE:    return 12'hF80;
            default: return 12'hFFF;
        endcase
    endfunction

    // integer bresenham walk that plots in-bounds points into the shadow image
    task automatic model_line(input int xa, input int ya, input int xb, input int yb,
                              input int c, output int npts);
        int x, y, dx, dy, sx, sy, err, e2;
        bit fin;
        x   = xa;
        y   = ya;
        dx  = (xb > xa) ? xb - xa : xa - xb;   // abs delta
        dy  = (yb > ya) ? ya - yb : yb - ya;   // negated abs delta
        sx  = (xb < xa) ? -1 : 1;
        sy  = (yb < ya) ? -1 : 1;
        err = dx + dy;
        npts = 0;
        fin  = 1'b0;
        while (!fin) begin
            npts++;
            if (x >= 0 && x < FB_WIDTH && y >= 0 && y < FB_HEIGHT)
                shadow[y*FB_WIDTH + x] = c[CIDXW-1:0];   // clipped points dropped
            if (x == xb && y == yb) begin
                fin = 1'b1;
            end else begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err += dy;
                    x   += sx;
                end
                if (e2 <= dx) begin
                    err += dx;
                    y   += sy;
                end
            end
        end
    endtask

    // reset for 2 cycles and then check the quiet outputs
    task automatic apply_reset();
        rst_sys = 1'b1;
        start   = 1'b0;
        repeat (2) @(negedge clk_sys);
        assert (!drawing && !done)
            else report_mismatch("drawing or done high during reset");
        assert (!de && !frame && !hsync && !vsync)
            else report_mismatch("de, frame or sync high during reset");
        assert ({vga_r, vga_g, vga_b} == '0)
            else report_mismatch($sformatf("rgb %03h during reset", {vga_r, vga_g, vga_b}));
        rst_sys = 1'b0;
    endtask

    // skip the rest of a comment line
    task automatic skip_comment(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1) ch = $fgetc(fd);
    endtask

    // one line request counted against the model until done
    task automatic run_line(input int xa, input int ya, input int xb, input int yb,
                            input int c);
        int expect_pts;
        int seen_pts;
        int waited;
        model_line(xa, ya, xb, yb, c, expect_pts);
        @(negedge clk_sys);                 // cycle after the previous done
        x0    = CORDW'(xa);
        y0    = CORDW'(ya);
        x1    = CORDW'(xb);
        y1    = CORDW'(yb);
        cidx  = c[CIDXW-1:0];
        start = 1'b1;
        @(negedge clk_sys);
        start    = 1'b0;
        seen_pts = 0;
        waited   = 0;
        while (!done && waited < 8*(FB_WIDTH + FB_HEIGHT)) begin
            if (drawing) begin
                seen_pts++;
                if (seen_pts == 2) begin    // stray request that must be ignored
                    x0    = '0;
                    y0    = '0;
                    x1    = CORDW'(FB_WIDTH - 1);
                    y1    = CORDW'(FB_HEIGHT - 1);
                    cidx  = ~c[CIDXW-1:0];
                    start = 1'b1;
                end
            end
            @(negedge clk_sys);
            start = 1'b0;
            waited++;
        end
        assert (done)
            else report_failure($sformatf("timed out waiting for done on line %0d", lines_drawn));
        assert (!drawing)
            else report_mismatch("drawing still high together with done");
        assert (seen_pts == expect_pts)
            else report_mismatch($sformatf("line %0d drew %0d points, expected %0d",
                                           lines_drawn, seen_pts, expect_pts));
        lines_drawn++;
    endtask

    // one whole frame from the frame pulse checked position by position
    task automatic check_frame();
        int waited;
        int i, h, v;
        logic             exp_de, exp_hs, exp_vs;
        logic [COLRW-1:0] exp_colr, got_colr;
        repeat (LAT_ADDR + LAT_SCAN + 2) @(negedge clk_sys);   // let writes land
        waited = 0;
        while (!frame && waited < 2*H_TOTAL*V_TOTAL + 16) begin
            @(negedge clk_sys);
            waited++;
        end
        assert (frame) else report_failure("timed out waiting for the frame pulse");
        for (i = 0; i < H_TOTAL*V_TOTAL; i++) begin
            h        = i % H_TOTAL;
            v        = i / H_TOTAL;
            exp_de   = (h < FB_WIDTH) && (v < FB_HEIGHT);
            exp_hs   = (h >= H_SYNC_START) && (h <= H_SYNC_END);
            exp_vs   = (v >= V_SYNC_START) && (v <= V_SYNC_END);
            exp_colr = exp_de ? palette_colr(shadow[v*FB_WIDTH + h]) : '0;
            got_colr = {vga_r, vga_g, vga_b};
            assert (de == exp_de)
                else report_mismatch($sformatf("de %0b at h %0d v %0d", de, h, v));
            assert (hsync == exp_hs && vsync == exp_vs)
                else report_mismatch($sformatf("sync %0b%0b at h %0d v %0d",
                                               hsync, vsync, h, v));
            assert (frame == (i == 0))
                else report_mismatch($sformatf("frame %0b at h %0d v %0d", frame, h, v));
            assert (got_colr == exp_colr)
                else report_mismatch($sformatf("rgb %03h at h %0d v %0d, expected %03h",
                                               got_colr, h, v, exp_colr));
            @(negedge clk_sys);
        end
        frames_checked++;
    endtask

    initial begin
        int         fd;
        int         rc;
        int         ax0, ay0, ax1, ay1, ac;
        int         i;
        logic [7:0] cmd;
        bit         reading;
        rst_sys = 1'b1;
        start   = 1'b0;
        x0      = '0;
        y0      = '0;
        x1      = '0;
        y1      = '0;
        cidx    = '0;
        frames_checked = 0;
        lines_drawn    = 0;
        for (i = 0; i < FB_PIXELS; i++) shadow[i] = '0;   // ram starts blank
        apply_reset();
        fd = $fopen("bench/line_tests.txt", "r");
        if (fd == 0) report_failure("could not open the test file bench/line_tests.txt");
        reading = 1'b1;
        while (reading) begin
            rc = $fscanf(fd, " %c", cmd);   // record letter
            if (rc != 1) begin
                reading = 1'b0;             // end of file
            end else begin
                case (cmd)
                    "#": skip_comment(fd);
                    "L": begin
                        rc = $fscanf(fd, " %d %d %d %d %d", ax0, ay0, ax1, ay1, ac);
                        if (rc != 5) report_failure("malformed line record in the test file");
                        run_line(ax0, ay0, ax1, ay1, ac);
                    end
                    "F": check_frame();
                    "R": apply_reset();         // shadow image stays as it is
                    default: report_failure($sformatf("unknown record %c in the test file",
                                                      cmd));
                endcase
            end
        end
        $fclose(fd);
        if (frames_checked > 0 && lines_drawn > 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            report_failure("the test file held no line or no frame check");
        end
    end

endmodule

// ==== build.f ====
logic/gfx_pkg.sv
logic/line_drawer.sv
logic/fb_write_addr.sv
logic/framebuffer_ram.sv
logic/raster_scanout.sv
logic/line_render_top.sv
bench/line_render_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal --Mdir obj_dir
TOP      = line_render_tb
FILELIST = build.f

.PHONY: sim clean

# build and run, exit status is the test result
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== bench/line_tests.txt ====
# record forms: L x0 y0 x1 y1 cidx draws a line, F checks one frame, R resets again
# coordinates are signed decimal, cidx is 0 to 15
F
L 2 3 40 3 1
L 40 6 2 6 2
L 5 9 5 40 3
L 8 40 8 9 4
L 12 10 32 30 5
L 50 30 30 10 6
L 20 45 40 25 8
L 1 44 61 20 9
L 44 46 58 2 10
L -10 -5 20 10 11
L -5 20 70 22 12
L 56 40 80 60 13
L 3 -10 30 60 14
L 0 0 63 47 15
F
R
F
